// ==== design/edge_defines.svh ====
`ifndef EDGE_DEFINES_SVH
`define EDGE_DEFINES_SVH

// Frame geometry, fixed at build time
`define EDGE_WIDTH 16
`define EDGE_HEIGHT 8

// Number of parallel Sobel lanes
`define EDGE_LANES 2

// APB register offsets
`define EDGE_CTRL_ADDR 8'h00
`define EDGE_FRAMES_ADDR 8'h04

`endif

// ==== design/edge_pkg.sv ====
`default_nettype none

package edge_pkg;

    // One grayscale sample
    typedef logic [7:0] pixel_t;

    // Stream beat, dispatcher to lanes and lanes to collector
    typedef struct packed {
        pixel_t data;
        logic   last;    // final pixel of a frame
    } px_beat_t;

    // Runtime settings held in CTRL
    typedef struct packed {
        logic       enable;
        logic [1:0] shift;
    } edge_cfg_t;

    // Request side of the APB bus
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

endpackage

`default_nettype wire

// ==== design/frame_dispatcher.sv ====
`default_nettype none

`include "edge_defines.svh"

module frame_dispatcher
    import edge_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  edge_cfg_t cfg,
    input  pixel_t    in_beat,
    input  logic      in_valid,
    output logic      in_ready,
    output px_beat_t  lane_beat [`EDGE_LANES],
    output logic      lane_valid [`EDGE_LANES],
    input  logic      lane_ready [`EDGE_LANES]
);

    localparam int PIX_COUNT = `EDGE_WIDTH * `EDGE_HEIGHT;
    localparam int PIX_W = $clog2(PIX_COUNT);
    localparam int PTR_W = (`EDGE_LANES > 1) ? $clog2(`EDGE_LANES) : 1;
    localparam logic [PIX_W-1:0] PIX_LAST = PIX_W'(PIX_COUNT - 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`EDGE_LANES - 1);

    // Position inside the current frame
    logic [PIX_W-1:0] pix_cnt;
    // Lane that receives the current frame
    logic [PTR_W-1:0] ptr;
    logic             in_last;
    logic             in_xfer;

    assign in_last = (pix_cnt == PIX_LAST);

    // Only the selected lane can take a pixel, and only while enabled
    assign in_ready = cfg.enable && lane_ready[ptr];
    assign in_xfer = in_valid && in_ready;

    // Data goes to every lane, valid only to the selected one
    always_comb begin
        for (int i = 0; i < `EDGE_LANES; i++) begin
            lane_beat[i].data = in_beat;
            lane_beat[i].last = in_last;
            lane_valid[i] = in_valid && cfg.enable && (ptr == PTR_W'(i));
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pix_cnt <= '0;
            ptr <= '0;
        end else if (in_xfer) begin
            if (in_last) begin
                // Frame boundary, next frame goes to the next lane
                pix_cnt <= '0;
                ptr <= (ptr == PTR_LAST) ? '0 : ptr + 1'b1;
            end else begin
                pix_cnt <= pix_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/sobel_lane.sv ====
`default_nettype none

`include "edge_defines.svh"

module sobel_lane
    import edge_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  edge_cfg_t cfg,
    input  px_beat_t  in_beat,
    input  logic      in_valid,
    output logic      in_ready,
    output px_beat_t  out_beat,
    output logic      out_valid,
    input  logic      out_ready
);

    localparam int W = `EDGE_WIDTH;
    localparam int H = `EDGE_HEIGHT;
    localparam int WIN_LEN = 2 * W + 3;
    localparam int COL_W = $clog2(W);
    localparam int ROW_W = $clog2(H);
    localparam int FILL_W = $clog2(W + 3);
    localparam logic [COL_W-1:0] COL_LAST = COL_W'(W - 1);
    localparam logic [ROW_W-1:0] ROW_LAST = ROW_W'(H - 1);
    // Window 0 is complete after W+2 pixels
    localparam logic [FILL_W-1:0] FILL_LAST = FILL_W'(W + 1);

    typedef enum logic [1:0] {S_FILL, S_CALC, S_HOLD} state_t;

    state_t state;

    // Index 0 is the newest pixel, index WIN_LEN-1 the oldest
    pixel_t [WIN_LEN-1:0] win;

    logic [FILL_W-1:0] fill_cnt;
    logic              primed;      // initial fill done
    logic              tail;        // input last seen, pad zeros from here
    logic [COL_W-1:0]  col;         // position of the output pixel
    logic [ROW_W-1:0]  row;
    logic [1:0]        frame_shift;

    logic   in_xfer;
    logic   take;
    pixel_t shift_px;
    logic   frame_end;
    logic   on_border;

    // 3x3 taps around the centre pixel
    pixel_t tl, tm, tr, ml, mr, bl, bm, br;
    logic [9:0]  gx_pos, gx_neg, gy_pos, gy_neg;
    logic [9:0]  gx_abs, gy_abs;
    logic [10:0] mag;
    logic [10:0] mag_sh;
    pixel_t      result;

    // Input is stalled outside FILL and while padding
    assign in_ready = (state == S_FILL) && !tail;
    assign in_xfer = in_valid && in_ready;
    // One shift per FILL cycle with input or padding
    assign take = in_xfer || ((state == S_FILL) && tail);
    assign shift_px = tail ? '0 : in_beat.data;

    assign out_valid = (state == S_HOLD);
    assign frame_end = (row == ROW_LAST) && (col == COL_LAST);
    assign on_border = (row == '0) || (row == ROW_LAST) || (col == '0) || (col == COL_LAST);

    assign tl = win[2*W+2];
    assign tm = win[2*W+1];
    assign tr = win[2*W];
    assign ml = win[W+2];
    assign mr = win[W];
    assign bl = win[2];
    assign bm = win[1];
    assign br = win[0];

    always_comb begin
        // Horizontal gradient, right column minus left column
        gx_pos = {2'b00, tr} + {1'b0, mr, 1'b0} + {2'b00, br};
        gx_neg = {2'b00, tl} + {1'b0, ml, 1'b0} + {2'b00, bl};
        // Vertical gradient, bottom row minus top row
        gy_pos = {2'b00, bl} + {1'b0, bm, 1'b0} + {2'b00, br};
        gy_neg = {2'b00, tl} + {1'b0, tm, 1'b0} + {2'b00, tr};
        // Magnitudes without signed arithmetic
        gx_abs = (gx_pos >= gx_neg) ? gx_pos - gx_neg : gx_neg - gx_pos;
        gy_abs = (gy_pos >= gy_neg) ? gy_pos - gy_neg : gy_neg - gy_pos;
        mag = {1'b0, gx_abs} + {1'b0, gy_abs};
        mag_sh = mag >> frame_shift;
        // Clamp to one byte
        result = (|mag_sh[10:8]) ? 8'hff : mag_sh[7:0];
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= S_FILL;
            fill_cnt <= '0;
            primed <= 1'b0;
            tail <= 1'b0;
            col <= '0;
            row <= '0;
            frame_shift <= '0;
        end else begin
            case (state)
                S_FILL: begin
                    if (in_xfer && in_beat.last) begin
                        tail <= 1'b1;
                    end
                    // Shift setting is frozen at the first pixel of the frame
                    if (in_xfer && !primed && (fill_cnt == '0)) begin
                        frame_shift <= cfg.shift;
                    end
                    if (take) begin
                        if (!primed) begin
                            fill_cnt <= fill_cnt + 1'b1;
                        end
                        // After priming, each output needs one more pixel
                        if (primed || (fill_cnt == FILL_LAST)) begin
                            primed <= 1'b1;
                            state <= S_CALC;
                        end
                    end
                end
                S_CALC: state <= S_HOLD;
                S_HOLD: begin
                    if (out_ready) begin
                        state <= S_FILL;
                        if (frame_end) begin
                            // Ready for the next frame
                            fill_cnt <= '0;
                            primed <= 1'b0;
                            tail <= 1'b0;
                            col <= '0;
                            row <= '0;
                        end else if (col == COL_LAST) begin
                            col <= '0;
                            row <= row + 1'b1;
                        end else begin
                            col <= col + 1'b1;
                        end
                    end
                end
                default: state <= S_FILL;
            endcase
        end
    end

    // Line window
    always_ff @(posedge clock) begin
        if ((state == S_HOLD) && out_ready && frame_end) begin
            win <= '0;
        end else if (take) begin
            win <= {win[WIN_LEN-2:0], shift_px};
        end
    end

    // Result register, held through HOLD
    always_ff @(posedge clock) begin
        if (state == S_CALC) begin
            out_beat.data <= on_border ? '0 : result;
            out_beat.last <= frame_end;
        end
    end

endmodule

`default_nettype wire

// ==== design/frame_collector.sv ====
`default_nettype none

`include "edge_defines.svh"

module frame_collector
    import edge_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  px_beat_t lane_beat [`EDGE_LANES],
    input  logic     lane_valid [`EDGE_LANES],
    output logic     lane_ready [`EDGE_LANES],
    output px_beat_t out_beat,
    output logic     out_valid,
    input  logic     out_ready,
    output logic     frame_done
);

    localparam int PTR_W = (`EDGE_LANES > 1) ? $clog2(`EDGE_LANES) : 1;
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`EDGE_LANES - 1);

    // Lane whose frame is being drained
    logic [PTR_W-1:0] ptr;

    // Pass the current lane straight through
    assign out_beat = lane_beat[ptr];
    assign out_valid = lane_valid[ptr];

    // Other lanes wait, which keeps output frames in input order
    always_comb begin
        for (int i = 0; i < `EDGE_LANES; i++) begin
            lane_ready[i] = out_ready && (ptr == PTR_W'(i));
        end
    end

    // Last pixel of a frame leaves the subsystem
    assign frame_done = out_valid && out_ready && out_beat.last;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ptr <= '0;
        end else if (frame_done) begin
            ptr <= (ptr == PTR_LAST) ? '0 : ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/edge_regs.sv ====
`default_nettype none

`include "edge_defines.svh"

module edge_regs
    import edge_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  apb_req_t    apb,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        frame_done,
    output edge_cfg_t   cfg
);

    logic        access;
    logic        hit_ctrl;
    logic        hit_frames;
    // Completed output frames
    logic [31:0] frames;

    // Access phase, always finished in one cycle
    assign access = apb.psel && apb.penable;
    assign pready = apb.penable;

    assign hit_ctrl = (apb.paddr == `EDGE_CTRL_ADDR);
    assign hit_frames = (apb.paddr == `EDGE_FRAMES_ADDR);

    // Unknown offsets error out for reads and writes
    assign pslverr = access && !hit_ctrl && !hit_frames;

    always_comb begin
        prdata = '0;
        if (access && !apb.pwrite) begin
            if (hit_ctrl) begin
                // Bit 0 enable, bits 2:1 shift
                prdata = {29'b0, cfg.shift, cfg.enable};
            end else if (hit_frames) begin
                prdata = frames;
            end
        end
    end

    // CTRL, visible the cycle after the access
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            cfg <= '0;
        end else if (access && apb.pwrite && hit_ctrl) begin
            cfg.enable <= apb.pwdata[0];
            cfg.shift <= apb.pwdata[2:1];
        end
    end

    // FRAMES is read only, writes there are dropped
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            frames <= '0;
        end else if (frame_done) begin
            frames <= frames + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/edge_top.sv ====
`default_nettype none

`include "edge_defines.svh"

module edge_top
    import edge_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  pixel_t      in_beat,
    input  logic        in_valid,
    output logic        in_ready,
    output px_beat_t    out_beat,
    output logic        out_valid,
    input  logic        out_ready,
    input  apb_req_t    apb,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    edge_cfg_t cfg;
    logic      frame_done;

    // Dispatcher to lanes
    px_beat_t lane_in_beat [`EDGE_LANES];
    logic     lane_in_valid [`EDGE_LANES];
    logic     lane_in_ready [`EDGE_LANES];
    // Lanes to collector
    px_beat_t lane_out_beat [`EDGE_LANES];
    logic     lane_out_valid [`EDGE_LANES];
    logic     lane_out_ready [`EDGE_LANES];

    edge_regs regs_i (
        .clock(clock), .reset(reset), .apb(apb), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .frame_done(frame_done), .cfg(cfg)
    );

    frame_dispatcher dispatcher_i (
        .clock(clock), .reset(reset), .cfg(cfg), .in_beat(in_beat), .in_valid(in_valid),
        .in_ready(in_ready), .lane_beat(lane_in_beat), .lane_valid(lane_in_valid),
        .lane_ready(lane_in_ready)
    );

    // One lane per frame in flight
    for (genvar i = 0; i < `EDGE_LANES; i++) begin : g_lane
        sobel_lane lane_i (
            .clock(clock), .reset(reset), .cfg(cfg),
            .in_beat(lane_in_beat[i]), .in_valid(lane_in_valid[i]),
            .in_ready(lane_in_ready[i]), .out_beat(lane_out_beat[i]),
            .out_valid(lane_out_valid[i]), .out_ready(lane_out_ready[i])
        );
    end

    frame_collector collector_i (
        .clock(clock), .reset(reset), .lane_beat(lane_out_beat),
        .lane_valid(lane_out_valid), .lane_ready(lane_out_ready), .out_beat(out_beat),
        .out_valid(out_valid), .out_ready(out_ready), .frame_done(frame_done)
    );

endmodule

`default_nettype wire

// ==== testbench/edge_assert.sv ====
`default_nettype none

module edge_assert
    import edge_pkg::*;
(
    input logic      clock,
    input logic      reset,
    input logic      in_ready,
    input px_beat_t  out_beat,
    input logic      out_valid,
    input logic      out_ready,
    input apb_req_t  apb,
    input logic      pready,
    input edge_cfg_t cfg
);

    // A stalled output beat stays put until it is taken
    out_held_a: assert property (@(posedge clock) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)))
        else $error("output beat changed while stalled");

    // Nothing enters while the subsystem is disabled
    idle_when_off_a: assert property (@(posedge clock) disable iff (reset)
        !cfg.enable |-> !in_ready)
        else $error("in_ready high with enable clear");

    // Zero wait state slave
    pready_a: assert property (@(posedge clock) disable iff (reset)
        pready == apb.penable)
        else $error("pready does not follow penable");

endmodule

bind edge_top edge_assert edge_assert_i (
    .clock(clock), .reset(reset), .in_ready(in_ready), .out_beat(out_beat),
    .out_valid(out_valid), .out_ready(out_ready), .apb(apb), .pready(pready),
    .cfg(cfg)
);

`default_nettype wire

// ==== testbench/edge_tb.sv ====
`default_nettype none

`include "edge_defines.svh"

module edge_tb
    import edge_pkg::*;
();

    localparam int W = `EDGE_WIDTH;
    localparam int H = `EDGE_HEIGHT;
    localparam int NPIX = W * H;
    // Longest wait for one handshake, in cycles
    localparam int STALL_LIMIT = 5000;

    logic        clock;
    logic        reset;
    pixel_t      in_beat;
    logic        in_valid;
    logic        in_ready;
    px_beat_t    out_beat;
    logic        out_valid;
    logic        out_ready;
    apb_req_t    apb;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    int          errors;
    int          checks;
    logic [31:0] lcg_state;
    pixel_t      frame_buf [NPIX];
    // Pixels still to send, beats still expected
    pixel_t      in_q [$];
    px_beat_t    exp_q [$];

    edge_top edge_top_i (
        .clock(clock), .reset(reset), .in_beat(in_beat), .in_valid(in_valid),
        .in_ready(in_ready), .out_beat(out_beat), .out_valid(out_valid),
        .out_ready(out_ready), .apb(apb), .prdata(prdata), .pready(pready),
        .pslverr(pslverr)
    );

    always #10 clock = ~clock;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int px(input int r, input int c);
        return int'(frame_buf[r * W + c]);
    endfunction

    task automatic abort_on_timeout(input string what);
        $display("Timeout waiting for %s after %0d cycles", what, STALL_LIMIT);
        $display("sim failed");
        $finish;
    endtask

    task automatic check_beat(input string test, input px_beat_t expected,
                              input px_beat_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected data %02h last %0b, actual data %02h last %0b",
                     test, expected.data, expected.last, actual.data, actual.last);
        end
    endtask

    task automatic check_word(input string test, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected %08h, actual %08h", test, expected, actual);
        end
    endtask

    task automatic check_flag(input string test, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected %0b, actual %0b", test, expected, actual);
        end
    endtask

    // Setup phase, then access phase until pready
    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        apb_req_t req;
        int       waited;
        req.psel = 1'b1;
        req.penable = 1'b0;
        req.pwrite = write;
        req.paddr = addr;
        req.pwdata = wdata;
        apb <= req;
        @(posedge clock);
        apb.penable <= 1'b1;
        // Response is sampled mid cycle, the access ends on the next rising edge
        @(negedge clock);
        waited = 0;
        while (!pready) begin
            if (waited == STALL_LIMIT) begin
                abort_on_timeout("APB pready");
            end
            waited++;
            @(negedge clock);
        end
        rdata = prdata;
        err = pslverr;
        @(posedge clock);
        apb <= '0;
    endtask

    task automatic read_reg(input string test, input logic [7:0] addr,
                            input logic [31:0] expected, input logic expected_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b0, addr, 32'h0, rdata, err);
        check_word(test, expected, rdata);
        check_flag({test, " pslverr"}, expected_err, err);
    endtask

    task automatic write_reg(input string test, input logic [7:0] addr,
                             input logic [31:0] wdata, input logic expected_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, wdata, rdata, err);
        check_flag({test, " pslverr"}, expected_err, err);
    endtask

    task automatic fill_random();
        logic [31:0] rnd;
        for (int i = 0; i < NPIX; i++) begin
            rnd = lcg_next();
            frame_buf[i] = rnd[23:16];
        end
    endtask

    // Black and white stripes two columns wide
    task automatic fill_stripes();
        for (int i = 0; i < NPIX; i++) begin
            frame_buf[i] = (((i % W) & 2) != 0) ? 8'hff : 8'h00;
        end
    endtask

    // Reference Sobel model, queues the frame and its expected output
    task automatic queue_frame(input int shift);
        int       gx;
        int       gy;
        int       mag;
        px_beat_t beat;
        for (int i = 0; i < NPIX; i++) begin
            in_q.push_back(frame_buf[i]);
        end
        for (int r = 0; r < H; r++) begin
            for (int c = 0; c < W; c++) begin
                // Border outputs stay zero
                mag = 0;
                if (r > 0 && r < H - 1 && c > 0 && c < W - 1) begin
                    // Right column minus left column
                    gx = px(r - 1, c + 1) + 2 * px(r, c + 1) + px(r + 1, c + 1)
                       - px(r - 1, c - 1) - 2 * px(r, c - 1) - px(r + 1, c - 1);
                    // Bottom row minus top row
                    gy = px(r + 1, c - 1) + 2 * px(r + 1, c) + px(r + 1, c + 1)
                       - px(r - 1, c - 1) - 2 * px(r - 1, c) - px(r - 1, c + 1);
                    mag = ((gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy)) >> shift;
                    mag = (mag > 255) ? 255 : mag;
                end
                beat.data = mag[7:0];
                beat.last = (r == H - 1) && (c == W - 1);
                exp_q.push_back(beat);
            end
        end
    endtask

    // Handshake is judged at the falling edge, transfer happens at the next rising edge
    task automatic send_pixels();
        int waited;
        while (in_q.size() > 0) begin
            in_beat <= in_q.pop_front();
            in_valid <= 1'b1;
            waited = 0;
            @(negedge clock);
            while (!in_ready) begin
                if (waited == STALL_LIMIT) begin
                    abort_on_timeout("in_ready");
                end
                waited++;
                @(negedge clock);
            end
            @(posedge clock);
        end
        in_valid <= 1'b0;
    endtask

    // Throttled mode drops out_ready on about half the cycles
    task automatic collect_beats(input string test, input logic throttle);
        logic [31:0] rnd;
        int          waited;
        int          index;
        px_beat_t    expected;
        index = 0;
        while (exp_q.size() > 0) begin
            rnd = lcg_next();
            out_ready <= !throttle || rnd[16];
            waited = 0;
            @(negedge clock);
            while (!(out_valid && out_ready)) begin
                if (waited == STALL_LIMIT) begin
                    abort_on_timeout($sformatf("%s output beat %0d", test, index));
                end
                waited++;
                @(posedge clock);
                rnd = lcg_next();
                out_ready <= !throttle || rnd[16];
                @(negedge clock);
            end
            expected = exp_q.pop_front();
            check_beat($sformatf("%s frame %0d pixel %0d", test, index / NPIX, index % NPIX),
                       expected, out_beat);
            index++;
            @(posedge clock);
        end
        out_ready <= 1'b0;
    endtask

    task automatic run_stream(input string test, input logic throttle);
        fork
            send_pixels();
            collect_beats(test, throttle);
        join
        // No stray beat after the last frame
        @(posedge clock);
        check_flag({test, " idle out_valid"}, 1'b0, out_valid);
    endtask

    task automatic test_registers();
        read_reg("reset ctrl", `EDGE_CTRL_ADDR, 32'h0, 1'b0);
        read_reg("reset frames", `EDGE_FRAMES_ADDR, 32'h0, 1'b0);
        write_reg("ctrl write", `EDGE_CTRL_ADDR, 32'h7, 1'b0);
        read_reg("ctrl readback", `EDGE_CTRL_ADDR, 32'h7, 1'b0);
        // Bits above shift are not stored
        write_reg("ctrl upper bits", `EDGE_CTRL_ADDR, 32'hffff_fff8, 1'b0);
        read_reg("ctrl upper readback", `EDGE_CTRL_ADDR, 32'h0, 1'b0);
        write_reg("frames write", `EDGE_FRAMES_ADDR, 32'h55, 1'b0);
        read_reg("frames read only", `EDGE_FRAMES_ADDR, 32'h0, 1'b0);
        read_reg("unknown read", 8'h08, 32'h0, 1'b1);
        write_reg("unknown write", 8'h0c, 32'h1, 1'b1);
    endtask

    task automatic test_disabled();
        write_reg("disable", `EDGE_CTRL_ADDR, 32'h0, 1'b0);
        in_beat <= 8'h5a;
        in_valid <= 1'b1;
        repeat (40) begin
            @(posedge clock);
            check_flag("disabled in_ready", 1'b0, in_ready);
        end
        in_valid <= 1'b0;
    endtask

    task automatic test_single_frame();
        // Enable with shift 1
        write_reg("single ctrl", `EDGE_CTRL_ADDR, 32'h3, 1'b0);
        fill_random();
        queue_frame(1);
        run_stream("single", 1'b0);
        read_reg("single frames", `EDGE_FRAMES_ADDR, 32'd1, 1'b0);
    endtask

    task automatic test_saturation();
        write_reg("saturation ctrl", `EDGE_CTRL_ADDR, 32'h1, 1'b0);
        fill_stripes();
        queue_frame(0);
        run_stream("saturation shift 0", 1'b0);
        write_reg("shift 3 ctrl", `EDGE_CTRL_ADDR, 32'h7, 1'b0);
        fill_stripes();
        queue_frame(3);
        run_stream("saturation shift 3", 1'b0);
        read_reg("saturation frames", `EDGE_FRAMES_ADDR, 32'd3, 1'b0);
    endtask

    // More frames than lanes, so every lane is reused
    task automatic test_lanes();
        write_reg("lanes ctrl", `EDGE_CTRL_ADDR, 32'h3, 1'b0);
        for (int f = 0; f < 4; f++) begin
            fill_random();
            queue_frame(1);
        end
        run_stream("lanes", 1'b1);
        read_reg("lanes frames", `EDGE_FRAMES_ADDR, 32'd7, 1'b0);
    endtask

    initial begin
        clock = 1'b0;
        errors = 0;
        checks = 0;
        lcg_state = 32'd50192;
        reset <= 1'b1;
        in_beat <= '0;
        in_valid <= 1'b0;
        out_ready <= 1'b0;
        apb <= '0;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        test_registers();
        test_disabled();
        test_single_frame();
        test_saturation();
        test_lanes();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+design
design/edge_pkg.sv
design/frame_dispatcher.sv
design/sobel_lane.sv
design/frame_collector.sv
design/edge_regs.sv
design/edge_top.sv
testbench/edge_assert.sv
testbench/edge_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module edge_tb -o edge_sim

# Keep the output even when the simulation stops early
output="$(./obj_dir/edge_sim)" || true
echo "$output"

if grep -qx "sim passed" <<< "$output"; then
    exit 0
fi
exit 1
